//--- rtl/fp_cluster_params.svh
/*
 * Sizing macros for the floating-point execution cluster.
 * Operands are IEEE-754 single precision, so the data width must stay 32.
 * The register count must equal 2 ** FP_REG_ADDR_WIDTH.
 */

`ifndef FP_CLUSTER_PARAMS_SVH
`define FP_CLUSTER_PARAMS_SVH

// Width of one operand and of one result word
`define FP_DATA_WIDTH 32

// Width of a destination register index
`define FP_REG_ADDR_WIDTH 4

// Number of entries in the result register file
`define FP_REG_COUNT 16

`endif

//--- rtl/fp_cluster_types_pkg.sv
/*
 * Operation and result stream types shared by the execution units.
 * Both streams are valid-only and have no ready signal.
 * Unused opcode values are ignored by every unit.
 */

`include "fp_cluster_params.svh"

package fp_cluster_types_pkg;

    // Opcodes on the operation stream
    typedef enum logic [2:0] {
        OP_NOP    = 3'd0,
        OP_MIN    = 3'd1,
        OP_MAX    = 3'd2,
        OP_CMP_LT = 3'd3,
        OP_CMP_LE = 3'd4,
        OP_CMP_EQ = 3'd5
    } fp_opcode_t;

    // One operation as it enters the cluster
    typedef struct packed {
        logic                          valid;
        fp_opcode_t                    opcode;
        logic [`FP_DATA_WIDTH-1:0]     operand_a;
        logic [`FP_DATA_WIDTH-1:0]     operand_b;
        logic [`FP_REG_ADDR_WIDTH-1:0] dest;
    } fp_operation_t;

    // A unit result, and the merged result stream
    typedef struct packed {
        logic                          valid;
        logic [`FP_DATA_WIDTH-1:0]     data;
        logic [`FP_REG_ADDR_WIDTH-1:0] dest;
    } fp_result_t;

endpackage

//--- rtl/fp_cluster_bus_pkg.sv
/*
 * APB types for the host read port of the cluster.
 * The port never inserts wait states, so pready is tied high.
 */

package fp_cluster_bus_pkg;

    // Signals driven by the APB master
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_request_t;

    // Signals driven back by the slave
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_response_t;

    // Transfer phase as seen by the slave
    typedef enum logic {
        APB_IDLE   = 1'b0,
        APB_ACCESS = 1'b1
    } apb_state_t;

endpackage

//--- rtl/fp_saturator.sv
/*
 * Min/max unit with a fixed latency of two cycles.
 * Floats are ordered by a signed integer compare with a fix for two negatives.
 * NaN and infinity get no special treatment.
 */

`timescale 1ns/1ps
`include "fp_cluster_params.svh"

module fp_saturator import fp_cluster_types_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  fp_operation_t operation,
    output fp_result_t    result
);

    logic                          claim;
    logic                          s1_valid;
    logic                          s1_is_max;
    logic [`FP_DATA_WIDTH-1:0]     s1_operand_a;
    logic [`FP_DATA_WIDTH-1:0]     s1_operand_b;
    logic [`FP_REG_ADDR_WIDTH-1:0] s1_dest;
    logic                          s1_a_greater_int;
    logic                          s1_both_negative;
    logic                          a_is_greater;
    logic                          out_valid;
    logic [`FP_DATA_WIDTH-1:0]     out_data;
    logic [`FP_REG_ADDR_WIDTH-1:0] out_dest;

    // This unit only takes min and max, everything else passes by
    assign claim = operation.valid && (operation.opcode inside {OP_MIN, OP_MAX});

    always_ff @(posedge clock) begin
        if (!reset) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= claim;
            out_valid <= s1_valid;
        end
    end

    // Stage one keeps the operands and does the integer compare
    always_ff @(posedge clock) begin
        if (claim) begin
            s1_is_max        <= (operation.opcode == OP_MAX);
            s1_operand_a     <= operation.operand_a;
            s1_operand_b     <= operation.operand_b;
            s1_dest          <= operation.dest;
            s1_a_greater_int <= $signed(operation.operand_a) > $signed(operation.operand_b);
            s1_both_negative <= operation.operand_a[`FP_DATA_WIDTH-1] &
                                operation.operand_b[`FP_DATA_WIDTH-1];
        end
    end

    // With both signs set, a larger integer means a larger magnitude, so a smaller float
    assign a_is_greater = s1_both_negative ^ s1_a_greater_int;

    // Stage two picks the operand
    always_ff @(posedge clock) begin
        if (s1_valid) begin
            if (s1_is_max == a_is_greater) begin
                out_data <= s1_operand_a;
            end else begin
                out_data <= s1_operand_b;
            end
            out_dest <= s1_dest;
        end
    end

    assign result = '{valid: out_valid, data: out_data, dest: out_dest};

endmodule

//--- rtl/fp_comparator.sv
/*
 * Compare unit for less-than, less-or-equal and equal, latency two cycles.
 * The result word is 1 when the relation holds and 0 otherwise.
 * Positive and negative zero compare equal; NaN is not handled.
 */

`timescale 1ns/1ps
`include "fp_cluster_params.svh"

module fp_comparator import fp_cluster_types_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  fp_operation_t operation,
    output fp_result_t    result
);

    logic                          claim;
    logic                          s1_valid;
    fp_opcode_t                    s1_opcode;
    logic [`FP_REG_ADDR_WIDTH-1:0] s1_dest;
    logic                          s1_a_less_int;
    logic                          s1_both_negative;
    logic                          s1_bit_equal;
    logic                          s1_both_zero;
    logic                          float_equal;
    logic                          float_less;
    logic                          relation;
    logic                          out_valid;
    logic                          out_flag;
    logic [`FP_REG_ADDR_WIDTH-1:0] out_dest;

    assign claim = operation.valid &&
                   (operation.opcode inside {OP_CMP_LT, OP_CMP_LE, OP_CMP_EQ});

    always_ff @(posedge clock) begin
        if (!reset) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= claim;
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (claim) begin
            s1_opcode        <= operation.opcode;
            s1_dest          <= operation.dest;
            s1_a_less_int    <= $signed(operation.operand_a) < $signed(operation.operand_b);
            s1_both_negative <= operation.operand_a[`FP_DATA_WIDTH-1] &
                                operation.operand_b[`FP_DATA_WIDTH-1];
            s1_bit_equal     <= (operation.operand_a == operation.operand_b);
            // Magnitudes of zero, whatever the sign bits say
            s1_both_zero     <= (operation.operand_a[`FP_DATA_WIDTH-2:0] == '0) &&
                                (operation.operand_b[`FP_DATA_WIDTH-2:0] == '0);
        end
    end

    assign float_equal = s1_bit_equal | s1_both_zero;

    // Two negatives reverse the integer order; equal words are never less
    assign float_less = !float_equal && (s1_both_negative ^ s1_a_less_int);

    always_comb begin
        case (s1_opcode)
            OP_CMP_LT: relation = float_less;
            OP_CMP_LE: relation = float_less | float_equal;
            OP_CMP_EQ: relation = float_equal;
            default:   relation = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (s1_valid) begin
            out_flag <= relation;
            out_dest <= s1_dest;
        end
    end

    assign result = '{valid: out_valid,
                      data:  {{(`FP_DATA_WIDTH-1){1'b0}}, out_flag},
                      dest:  out_dest};

endmodule

//--- rtl/fp_writeback.sv
/*
 * Merges the unit results into the register file and the result stream.
 * The two unit results must never be valid in the same cycle.
 * APB paddr is a byte address: register n at 4*n, the count at 0x40.
 * Only reads are supported; writes and other addresses give pslverr.
 */

`timescale 1ns/1ps
`include "fp_cluster_params.svh"

module fp_writeback import fp_cluster_types_pkg::*, fp_cluster_bus_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  fp_result_t    saturator_result,
    input  fp_result_t    comparator_result,
    output fp_result_t    result,
    input  apb_request_t  apb_request,
    output apb_response_t apb_response
);

    fp_result_t                    merged;
    logic                          out_valid;
    logic [`FP_DATA_WIDTH-1:0]     out_data;
    logic [`FP_REG_ADDR_WIDTH-1:0] out_dest;
    logic [`FP_DATA_WIDTH-1:0]     reg_file [`FP_REG_COUNT];
    logic [31:0]                   op_count;
    apb_state_t                    apb_state;
    logic                          access;
    logic [5:0]                    word;

    // At most one unit is valid, so the saturator simply wins the mux
    assign merged = saturator_result.valid ? saturator_result : comparator_result;

    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
            op_count  <= '0;
        end else begin
            out_valid <= merged.valid;
            if (merged.valid) begin
                op_count <= op_count + 32'd1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (merged.valid) begin
            out_data <= merged.data;
            out_dest <= merged.dest;
        end
    end

    // The host must read zeros after reset, so the file is cleared
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `FP_REG_COUNT; i++) begin
                reg_file[i] <= '0;
            end
        end else if (merged.valid) begin
            reg_file[merged.dest] <= merged.data;
        end
    end

    assign result = '{valid: out_valid, data: out_data, dest: out_dest};

    // Setup phase moves to access, access always returns to idle
    always_ff @(posedge clock) begin
        if (!reset) begin
            apb_state <= APB_IDLE;
        end else begin
            case (apb_state)
                APB_IDLE: begin
                    if (apb_request.psel && !apb_request.penable) begin
                        apb_state <= APB_ACCESS;
                    end
                end
                APB_ACCESS: apb_state <= APB_IDLE;
                default:    apb_state <= APB_IDLE;
            endcase
        end
    end

    assign access = (apb_state == APB_ACCESS) && apb_request.psel && apb_request.penable;
    assign word   = apb_request.paddr[7:2];

    // Read data is combinational during the access phase
    always_comb begin
        apb_response.pready  = 1'b1;
        apb_response.prdata  = '0;
        apb_response.pslverr = 1'b0;
        if (access) begin
            if (apb_request.pwrite) begin
                apb_response.pslverr = 1'b1;
            end else if (word < `FP_REG_COUNT) begin
                apb_response.prdata = reg_file[word[`FP_REG_ADDR_WIDTH-1:0]];
            end else if (word == `FP_REG_COUNT) begin
                apb_response.prdata = op_count;
            end else begin
                apb_response.pslverr = 1'b1;
            end
        end
    end

endmodule

//--- rtl/fp_cluster.sv
/*
 * Top level of the floating-point execution cluster.
 * Fixed latency of three cycles from operation to result, no back-pressure.
 * At most one operation may enter per cycle.
 */

`timescale 1ns/1ps

module fp_cluster import fp_cluster_types_pkg::*, fp_cluster_bus_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  fp_operation_t operation,
    output fp_result_t    result,
    input  apb_request_t  apb_request,
    output apb_response_t apb_response
);

    fp_result_t saturator_result;
    fp_result_t comparator_result;

    // Both units see every operation and pick out their own opcodes
    fp_saturator saturator_i (
        .clock     (clock),
        .reset     (reset),
        .operation (operation),
        .result    (saturator_result)
    );

    fp_comparator comparator_i (
        .clock     (clock),
        .reset     (reset),
        .operation (operation),
        .result    (comparator_result)
    );

    fp_writeback writeback_i (
        .clock             (clock),
        .reset             (reset),
        .saturator_result  (saturator_result),
        .comparator_result (comparator_result),
        .result            (result),
        .apb_request       (apb_request),
        .apb_response      (apb_response)
    );

endmodule

//--- bench/fp_cluster_clock.sv
/*
 * Clock and reset source for the cluster testbench.
 * 8 ns clock period; reset is held low for the first 16 rising edges.
 */

`timescale 1ns/1ps

module fp_cluster_clock (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        reset = 1'b0;
        repeat (16) @(posedge clock);
        reset <= 1'b1;
    end

endmodule

//--- bench/fp_cluster_assert.sv
/*
 * Concurrent checks bound into every fp_writeback instance.
 * The operation is taken from the enclosing fp_cluster by an upward reference,
 * so the writeback must sit directly inside an fp_cluster.
 */

`timescale 1ns/1ps

module fp_cluster_assert import fp_cluster_types_pkg::*, fp_cluster_bus_pkg::*; (
    input logic          clock,
    input logic          reset,
    input fp_result_t    saturator_result,
    input fp_result_t    comparator_result,
    input fp_result_t    result,
    input apb_request_t  apb_request,
    input fp_operation_t operation
);

    units_exclusive: assert property (@(posedge clock) disable iff (!reset)
        !(saturator_result.valid && comparator_result.valid))
        else $error("Both execution units delivered a result in the same cycle");

    penable_needs_psel: assert property (@(posedge clock) disable iff (!reset)
        apb_request.penable |-> apb_request.psel)
        else $error("APB penable is high without psel");

    setup_then_access: assert property (@(posedge clock) disable iff (!reset)
        (apb_request.psel && !apb_request.penable) |=> (apb_request.psel && apb_request.penable))
        else $error("APB setup phase is not followed by an access phase");

    // The DUT takes the operation three edges before the edge that samples its result
    result_has_operation: assert property (@(posedge clock) disable iff (!reset)
        result.valid |-> $past(operation.valid, 3) && ($past(operation.opcode, 3) != OP_NOP) &&
                         ($past(operation.dest, 3) == result.dest))
        else $error("Valid result without a matching operation three cycles before");

endmodule

bind fp_writeback fp_cluster_assert assert_i (
    .clock             (clock),
    .reset             (reset),
    .saturator_result  (saturator_result),
    .comparator_result (comparator_result),
    .result            (result),
    .apb_request       (apb_request),
    .operation         (fp_cluster.operation)
);

//--- bench/fp_cluster_tb.sv
/*
 * Trace-driven testbench for the floating-point cluster.
 * Must run from the project root so that bench/fp_cluster_trace.txt is found.
 * Random extra min/max operations only target register 15 and the trace never reads it.
 */

`timescale 1ns/1ps
`include "fp_cluster_params.svh"

module fp_cluster_tb import fp_cluster_types_pkg::*, fp_cluster_bus_pkg::*; ();

    logic          clock;
    logic          reset;
    fp_operation_t operation;
    fp_result_t    result;
    apb_request_t  apb_request;
    apb_response_t apb_response;
    fp_result_t    exp_in;
    string         exp_name;
    fp_result_t    exp_q[$];
    string         name_q[$];
    string         lines[$];
    logic [31:0]   lcg_state;
    int            in_flight;
    int            extra_count;
    logic          gaps_on;
    logic          trace_loaded;

    fp_cluster_clock clock_i (.clock(clock), .reset(reset));

    fp_cluster dut_i (
        .clock        (clock),
        .reset        (reset),
        .operation    (operation),
        .result       (result),
        .apb_request  (apb_request),
        .apb_response (apb_response)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // A positive word beats a negative one, and among negatives the smaller
    // magnitude is the greater float
    function automatic logic [`FP_DATA_WIDTH-1:0] saturate_model(logic [31:0] a, logic [31:0] b,
                                                                 logic is_max);
        logic a_greater;
        if (a[31] != b[31]) begin
            a_greater = !a[31];
        end else if (!a[31]) begin
            a_greater = a[30:0] > b[30:0];
        end else begin
            a_greater = a[30:0] < b[30:0];
        end
        return (is_max == a_greater) ? a : b;
    endfunction

    task automatic compare_result(string name, fp_result_t expected, fp_result_t actual);
        if (actual.valid !== expected.valid || (expected.valid && actual !== expected)) begin
            $display("CHECK FAILED %s: expected result %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic compare_apb(string name, apb_response_t expected, apb_response_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected APB response %h, actual %h",
                     name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "APB mismatch");
        end
    endtask

    task automatic issue_op(logic [2:0] opcode, logic [31:0] a, logic [31:0] b,
                            logic [3:0] dest, logic [31:0] expected, string name);
        @(posedge clock);
        operation <= '{valid: 1'b1, opcode: fp_opcode_t'(opcode), operand_a: a,
                       operand_b: b, dest: dest};
        exp_in    <= '{valid: 1'b1, data: expected, dest: dest};
        exp_name  <= name;
        in_flight++;
    endtask

    task automatic idle_cycle();
        @(posedge clock);
        operation <= '0;
        exp_in    <= '0;
        exp_name  <= "idle";
    endtask

    // Wait until every issued operation has been seen on the result stream
    task automatic drain();
        idle_cycle();
        while (in_flight != 0) @(negedge clock);
    endtask

    task automatic random_filler();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        r = next_random();
        if (r[2:0] == 3'd0) begin
            idle_cycle();
        end
        if (r[6:4] < 3'd2) begin
            a = next_random();
            b = next_random();
            issue_op(r[8] ? OP_MAX : OP_MIN, a, b, 4'hf, saturate_model(a, b, r[8]),
                     "random min/max");
            extra_count++;
        end
    endtask

    task automatic apb_transfer(logic write, logic [7:0] addr, logic [31:0] wdata,
                                logic [31:0] rdata, logic slverr, string name);
        apb_response_t expected;
        expected = '{prdata: rdata, pready: 1'b1, pslverr: slverr};
        @(posedge clock);
        apb_request <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clock);
        apb_request.penable <= 1'b1;
        do @(negedge clock); while (apb_response.pready !== 1'b1);
        compare_apb(name, expected, apb_response);
        @(posedge clock);
        apb_request <= '0;
    endtask

    task automatic run_line(string line, int number);
        byte         kind;
        logic [31:0] f1, f2, f3, f4, f5;
        string       name;
        if (line.len() < 2 || line[0] == "#") return;
        void'($sscanf(line, "%c %h %h %h %h %h", kind, f1, f2, f3, f4, f5));
        name = $sformatf("trace line %0d", number);
        case (kind)
            "O": begin
                if (gaps_on) random_filler();
                issue_op(f1[2:0], f2, f3, f4[3:0], f5, name);
            end
            "R": begin
                // The trace counts only its own operations and the bench adds the inserted ones
                if (f1[7:0] == 8'h40 && !f3[0]) f2 = f2 + extra_count;
                drain();
                apb_transfer(1'b0, f1[7:0], 32'h0, f2, f3[0], name);
            end
            "W": begin
                drain();
                apb_transfer(1'b1, f1[7:0], f2, 32'h0, f3[0], name);
            end
            "G": gaps_on = f1[0];
            default: begin
                $display("Unknown record kind on trace line %0d", number);
                $display("Simulation failed");
                $fatal(1, "bad trace");
            end
        endcase
    endtask

    // The result of an operation shows on the third falling edge after the one
    // where the operation is first seen
    always @(negedge clock) begin : monitor
        fp_result_t expected;
        string      name;
        exp_q.push_back(exp_in);
        name_q.push_back(exp_name);
        if (exp_q.size() > 3) begin
            expected = exp_q.pop_front();
            name     = name_q.pop_front();
            compare_result(name, expected, result);
            if (expected.valid) in_flight--;
        end
    end

    initial begin : watchdog
        wait (trace_loaded === 1'b1);
        repeat (lines.size() * 20 + 200) @(posedge clock);
        $display("Timeout: the run did not finish within %0d cycles", lines.size() * 20 + 200);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    initial begin : main
        int    fd;
        int    code;
        string line;
        operation    = '0;
        apb_request  = '0;
        exp_in       = '0;
        exp_name     = "idle";
        lcg_state    = 32'h2b233c7c;
        in_flight    = 0;
        extra_count  = 0;
        gaps_on      = 1'b0;
        trace_loaded = 1'b0;
        fd = $fopen("bench/fp_cluster_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open bench/fp_cluster_trace.txt");
            $display("Simulation failed");
            $fatal(1, "no trace");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0) lines.push_back(line);
            end
            $fclose(fd);
            trace_loaded = 1'b1;
            wait (reset === 1'b1);
            foreach (lines[i]) run_line(lines[i], i + 1);
            drain();
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

//--- bench/fp_cluster_trace.txt
# O opcode a b dest expected_data   (opcode 1 min, 2 max, 3 lt, 4 le, 5 eq; all hex)
# R paddr expected_data pslverr | W paddr wdata pslverr | G random_gaps_on
R 00 00000000 0
R 14 00000000 0
R 40 00000000 0
G 1
# Min and max on both positive, both negative, mixed signs and equal operands
O 2 3f800000 40000000 0 40000000
O 1 3f800000 40000000 1 3f800000
O 2 bf800000 c0000000 2 bf800000
O 1 bf800000 c0000000 3 c0000000
O 2 c0400000 3f000000 4 3f000000
O 1 c0400000 3f000000 5 c0400000
O 2 40400000 40400000 6 40400000
O 1 bf000000 bf000000 7 bf000000
# Compares with negatives, signed zeros and equal operands
O 3 c0000000 bf800000 8 00000001
O 3 bf800000 c0000000 9 00000000
O 5 00000000 80000000 a 00000001
O 4 40a00000 40a00000 b 00000001
O 3 80000000 00000000 c 00000000
O 4 3fc00000 3f800000 d 00000000
G 0
# Back to back, alternating units
O 2 40000000 c0000000 0 40000000
O 3 3f800000 40000000 1 00000001
O 1 40a00000 3fc00000 2 3fc00000
O 5 3f800000 bf800000 3 00000000
O 2 c0400000 c0000000 4 c0000000
O 4 c0400000 c0000000 5 00000001
# Register file and count
R 00 40000000 0
R 04 00000001 0
R 08 3fc00000 0
R 0c 00000000 0
R 10 c0000000 0
R 14 00000001 0
R 18 40400000 0
R 1c bf000000 0
R 20 00000001 0
R 28 00000001 0
R 34 00000000 0
R 40 00000014 0
# Writes and unmapped reads
W 00 deadbeef 1
W 40 12345678 1
R 44 00000000 1
R fc 00000000 1
R 00 40000000 0
R 40 00000014 0

//--- fp_cluster.f
+incdir+rtl
rtl/fp_cluster_types_pkg.sv
rtl/fp_cluster_bus_pkg.sv
rtl/fp_saturator.sv
rtl/fp_comparator.sv
rtl/fp_writeback.sv
rtl/fp_cluster.sv
bench/fp_cluster_clock.sv
bench/fp_cluster_assert.sv
bench/fp_cluster_tb.sv

//--- Bender.yml
package:
  name: fp_cluster

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fp_cluster_types_pkg.sv
      - rtl/fp_cluster_bus_pkg.sv
      - rtl/fp_saturator.sv
      - rtl/fp_comparator.sv
      - rtl/fp_writeback.sv
      - rtl/fp_cluster.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/fp_cluster_clock.sv
      - bench/fp_cluster_assert.sv
      - bench/fp_cluster_tb.sv
